//--- logic/archimedes_io_pkg.sv
package archimedes_io_pkg;

	// address bits 25:22 that select I/O space
	localparam logic [3:0] IO_REGION = 4'b1100;

	// bank codes in address bits 18:16
	localparam logic [2:0] IOC_BANK = 3'd0;
	localparam logic [2:0] POD_BANK = 3'd4;
	localparam logic [2:0] LATCH_BANK = 3'd5;

	// latches only answer at this speed code (bits 20:19)
	localparam logic [1:0] LATCH_SPEED = 2'd2;

	localparam int IOC_REGS = 8;
	localparam int POD_REGS = 16;

	// drive selects are active low, so all drives start deselected
	localparam logic [7:0] LATCH_A_RST = 8'hFF;

	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_IOC,
		TGT_POD,
		TGT_LATCH
	} io_target_e;

	// addr holds byte address bits 25:2
	typedef struct packed {
		logic        we;
		logic [23:0] addr;
		logic [31:0] wdata;
	} io_req_t;

	typedef struct packed {
		logic        we;
		io_target_e  target;
		logic [3:0]  index;
		logic [31:0] wdata;
	} io_cmd_t;

	typedef struct packed {
		io_target_e  target;
		logic [15:0] rdata;
	} io_rd_t;

	typedef struct packed {
		logic [31:0] rdata;
	} io_rsp_t;

	typedef struct packed {
		logic [3:0] floppy_drive;
		logic       floppy_side;
		logic       floppy_motor;
		logic       floppy_inuse;
		logic       floppy_density;
		logic       floppy_reset;
		logic [1:0] baseclk;
		logic [1:0] syncpol;
	} latch_out_t;

endpackage

//--- logic/io_access_decode.sv
`timescale 1ns/10ps

module io_access_decode
	import archimedes_io_pkg::*;
(
	input  logic    clkcpu_i,
	input  logic    rst_n_i,
	input  logic    req_stb_i,
	input  io_req_t req_i,
	output logic    cmd_vld_o,
	output io_cmd_t cmd_o
);

	// field views of the word address
	logic [3:0] region;
	logic       ioc_sel;
	logic [1:0] speed;
	logic [2:0] bank;

	io_target_e target;
	logic [3:0] index;

	assign region  = req_i.addr[23:20];
	assign ioc_sel = req_i.addr[19];
	assign speed   = req_i.addr[18:17];
	assign bank    = req_i.addr[16:14];

	// the first matching decode rule wins
	always_comb begin
		target = TGT_NONE;
		index  = 4'd0;
		if (region == IO_REGION) begin
			if (ioc_sel && bank == IOC_BANK) begin
				target = TGT_IOC;
				index  = {1'b0, req_i.addr[2:0]};
			end else if (bank == POD_BANK) begin
				target = TGT_POD;
				index  = req_i.addr[3:0];
			end else if (bank == LATCH_BANK && speed == LATCH_SPEED) begin
				target = TGT_LATCH;
				index  = {2'b00, req_i.addr[1:0]};
			end
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			cmd_vld_o <= 1'b0;
		end else begin
			cmd_vld_o <= req_stb_i;
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (req_stb_i) begin
			cmd_o.we     <= req_i.we;
			cmd_o.target <= target;
			cmd_o.index  <= index;
			cmd_o.wdata  <= req_i.wdata;
		end
	end

	// every strobe carries a fully driven request
	assert property (@(posedge clkcpu_i) disable iff (!rst_n_i)
		req_stb_i |-> !$isunknown(req_i));

endmodule

//--- logic/io_reg_bank.sv
`timescale 1ns/10ps

module io_reg_bank
	import archimedes_io_pkg::*;
#(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = IOC_REGS
) (
	input  logic       clkcpu_i,
	input  logic       rst_n_i,
	input  logic       wr_en_i,
	input  logic [3:0] idx_i,
	input  payload_t   wdata_i,
	output payload_t   rdata_o
);

	payload_t regs [DEPTH];

	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i) begin
			regs[idx_i[$clog2(DEPTH)-1:0]] <= wdata_i;
		end
	end

	// read is combinational so a write lands before the next read
	assign rdata_o = regs[idx_i[$clog2(DEPTH)-1:0]];

	// decode must never hand this bank an index past its end
	assert property (@(posedge clkcpu_i) disable iff (!rst_n_i)
		wr_en_i |-> idx_i < DEPTH);

endmodule

//--- logic/io_latches.sv
`timescale 1ns/10ps

module io_latches
	import archimedes_io_pkg::*;
(
	input  logic       clkcpu_i,
	input  logic       rst_n_i,
	input  logic       wr_en_i,
	input  logic [1:0] idx_i,
	input  logic [7:0] wdata_i,
	input  logic [4:0] joy0_i,
	input  logic [4:0] joy1_i,
	output logic [7:0] rdata_o,
	output latch_out_t latch_o,
	output logic       debug_led_o
);

	logic [7:0] latch_a;
	logic [7:0] latch_b;
	logic [7:0] latch_c;
	logic [7:0] joy_port;

	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			latch_a <= LATCH_A_RST;
			latch_b <= 8'h00;
			latch_c <= 8'h00;
		end else if (wr_en_i) begin
			case (idx_i)
				2'd0: latch_a <= wdata_i;
				2'd1: latch_b <= wdata_i;
				2'd2: latch_c <= wdata_i;
				// joystick port ignores writes
				default: ;
			endcase
		end
	end

	// joystick lines are active low
	assign joy_port = {~joy1_i[2:0], ~joy0_i};

	always_comb begin
		case (idx_i)
			2'd0:    rdata_o = latch_a;
			2'd1:    rdata_o = latch_b;
			2'd2:    rdata_o = latch_c;
			default: rdata_o = joy_port;
		endcase
	end

	// latch A drives the floppy control lines
	assign latch_o.floppy_drive = latch_a[3:0];
	assign latch_o.floppy_side  = latch_a[4];
	assign latch_o.floppy_motor = latch_a[5];
	assign latch_o.floppy_inuse = latch_a[6];

	// latch B
	assign latch_o.floppy_density = latch_b[1];
	assign latch_o.floppy_reset   = latch_b[3];

	// latch C holds the video enhancer selects
	assign latch_o.baseclk = latch_c[1:0];
	assign latch_o.syncpol = latch_c[3:2];

	// LED lights up (goes low) only with drive 0 selected and in use
	assign debug_led_o = ~(~latch_o.floppy_inuse & ~latch_o.floppy_drive[0]);

endmodule

//--- logic/io_execute.sv
`timescale 1ns/10ps

module io_execute
	import archimedes_io_pkg::*;
(
	input  logic       clkcpu_i,
	input  logic       rst_n_i,
	input  logic       cmd_vld_i,
	input  io_cmd_t    cmd_i,
	input  logic [4:0] joy0_i,
	input  logic [4:0] joy1_i,
	output logic       rd_vld_o,
	output io_rd_t     rd_o,
	output latch_out_t latch_o,
	output logic       debug_led_o
);

	logic        wr;
	logic [7:0]  ioc_rdata;
	logic [15:0] pod_rdata;
	logic [7:0]  latch_rdata;
	logic [15:0] rdata;

	assign wr = cmd_vld_i & cmd_i.we;

	io_reg_bank #(
		.payload_t (logic [7:0]),
		.DEPTH     (IOC_REGS)
	) ioc_bank (
		.clkcpu_i (clkcpu_i),
		.rst_n_i  (rst_n_i),
		.wr_en_i  (wr && cmd_i.target == TGT_IOC),
		.idx_i    (cmd_i.index),
		.wdata_i  (cmd_i.wdata[23:16]),
		.rdata_o  (ioc_rdata)
	);

	io_reg_bank #(
		.payload_t (logic [15:0]),
		.DEPTH     (POD_REGS)
	) pod_bank (
		.clkcpu_i (clkcpu_i),
		.rst_n_i  (rst_n_i),
		.wr_en_i  (wr && cmd_i.target == TGT_POD),
		.idx_i    (cmd_i.index),
		.wdata_i  (cmd_i.wdata[15:0]),
		.rdata_o  (pod_rdata)
	);

	io_latches latches (
		.clkcpu_i    (clkcpu_i),
		.rst_n_i     (rst_n_i),
		.wr_en_i     (wr && cmd_i.target == TGT_LATCH),
		.idx_i       (cmd_i.index[1:0]),
		.wdata_i     (cmd_i.wdata[23:16]),
		.joy0_i      (joy0_i),
		.joy1_i      (joy1_i),
		.rdata_o     (latch_rdata),
		.latch_o     (latch_o),
		.debug_led_o (debug_led_o)
	);

	// read source by target
	always_comb begin
		case (cmd_i.target)
			TGT_IOC:   rdata = {8'h00, ioc_rdata};
			TGT_POD:   rdata = pod_rdata;
			TGT_LATCH: rdata = {8'h00, latch_rdata};
			default:   rdata = 16'hFFFF;
		endcase
	end

	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			rd_vld_o <= 1'b0;
		end else begin
			rd_vld_o <= cmd_vld_i;
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (cmd_vld_i) begin
			rd_o.target <= cmd_i.target;
			rd_o.rdata  <= rdata;
		end
	end

endmodule

//--- logic/io_read_return.sv
`timescale 1ns/10ps

module io_read_return
	import archimedes_io_pkg::*;
(
	input  logic    clkcpu_i,
	input  logic    rst_n_i,
	input  logic    rd_vld_i,
	input  io_rd_t  rd_i,
	output logic    ack_o,
	output io_rsp_t rsp_o
);

	logic [31:0] wide;

	// byte targets use the low lane only and unmapped reads float high
	always_comb begin
		case (rd_i.target)
			TGT_IOC,
			TGT_LATCH: wide = {24'h000000, rd_i.rdata[7:0]};
			TGT_POD:   wide = {16'h0000, rd_i.rdata};
			default:   wide = 32'hFFFF_FFFF;
		endcase
	end

	always_ff @(posedge clkcpu_i) begin
		if (!rst_n_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= rd_vld_i;
		end
	end

	always_ff @(posedge clkcpu_i) begin
		if (rd_vld_i) begin
			rsp_o.rdata <= wide;
		end
	end

	// an acknowledged response never carries undriven data
	assert property (@(posedge clkcpu_i) disable iff (!rst_n_i)
		ack_o |-> !$isunknown(rsp_o));

endmodule

//--- logic/archimedes_io_top.sv
`timescale 1ns/10ps

module archimedes_io_top
	import archimedes_io_pkg::*;
(
	input  logic       clkcpu_i,
	input  logic       rst_n_i,
	input  logic       req_stb_i,
	input  io_req_t    req_i,
	input  logic [4:0] joy0_i,
	input  logic [4:0] joy1_i,
	output logic       ack_o,
	output io_rsp_t    rsp_o,
	output latch_out_t latch_o,
	output logic       debug_led_o
);

	logic    cmd_vld;
	io_cmd_t cmd;
	logic    rd_vld;
	io_rd_t  rd;

	io_access_decode decode (
		.clkcpu_i  (clkcpu_i),
		.rst_n_i   (rst_n_i),
		.req_stb_i (req_stb_i),
		.req_i     (req_i),
		.cmd_vld_o (cmd_vld),
		.cmd_o     (cmd)
	);

	io_execute execute (
		.clkcpu_i    (clkcpu_i),
		.rst_n_i     (rst_n_i),
		.cmd_vld_i   (cmd_vld),
		.cmd_i       (cmd),
		.joy0_i      (joy0_i),
		.joy1_i      (joy1_i),
		.rd_vld_o    (rd_vld),
		.rd_o        (rd),
		.latch_o     (latch_o),
		.debug_led_o (debug_led_o)
	);

	io_read_return result (
		.clkcpu_i (clkcpu_i),
		.rst_n_i  (rst_n_i),
		.rd_vld_i (rd_vld),
		.rd_i     (rd),
		.ack_o    (ack_o),
		.rsp_o    (rsp_o)
	);

endmodule

//--- test/tb_archimedes_io.sv
`timescale 1ns/10ps

module tb_archimedes_io
	import archimedes_io_pkg::*;
();

	// one case is FIELDS words in the data file
	localparam int FIELDS    = 9;
	localparam int MAX_CASES = 64;

	typedef struct packed {
		logic [31:0] due;
		logic        is_read;
		io_rsp_t     rsp;
	} rsp_exp_t;

	typedef struct packed {
		logic [31:0] due;
		logic        led;
		latch_out_t  latch;
	} latch_exp_t;

	logic        clkcpu = 1'b0;
	logic        rst_n;
	logic        req_stb;
	io_req_t     req;
	logic [4:0]  joy0;
	logic [4:0]  joy1;
	logic        ack;
	io_rsp_t     rsp;
	latch_out_t  latch;
	logic        debug_led;

	logic [31:0] case_mem [MAX_CASES*FIELDS];
	logic [15:0] pod_model [POD_REGS];
	logic [31:0] rng_state;
	logic [31:0] cycle = 32'd0;
	int          num_cases;
	int          data_errors;
	int          proto_errors;
	rsp_exp_t    rsp_q [$];
	latch_exp_t  latch_q [$];
	rsp_exp_t    rsp_e;
	latch_exp_t  latch_e;

	archimedes_io_top archimedes_io_top_inst (
		.clkcpu_i    (clkcpu),
		.rst_n_i     (rst_n),
		.req_stb_i   (req_stb),
		.req_i       (req),
		.joy0_i      (joy0),
		.joy1_i      (joy1),
		.ack_o       (ack),
		.rsp_o       (rsp),
		.latch_o     (latch),
		.debug_led_o (debug_led)
	);

	always #4 clkcpu = ~clkcpu;

	always @(posedge clkcpu) begin
		cycle <= cycle + 32'd1;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_rsp(input io_rsp_t got, input io_rsp_t exp);
		if (got !== exp) begin
			$display("** Error at %0t: read data %h, expected %h", $time, got.rdata, exp.rdata);
			data_errors++;
		end
	endtask

	task automatic check_latch(input latch_out_t got, input logic got_led,
			input latch_out_t exp, input logic exp_led);
		if (got !== exp || got_led !== exp_led) begin
			$display("** Error at %0t: latch %h led %b, expected latch %h led %b",
				$time, got, got_led, exp, exp_led);
			data_errors++;
		end
	endtask

	// outputs sampled mid cycle, away from the driving edge
	always @(negedge clkcpu) begin
		if (ack) begin
			if (rsp_q.size() == 0) begin
				$display("acknowledge at %0t with no access outstanding", $time);
				proto_errors++;
			end else begin
				rsp_e = rsp_q.pop_front();
				if (rsp_e.due != cycle) begin
					$display("acknowledge in cycle %0d, expected in cycle %0d", cycle, rsp_e.due);
					proto_errors++;
				end
				if (rsp_e.is_read) begin
					check_rsp(rsp, rsp_e.rsp);
				end
			end
		end else if (rsp_q.size() > 0 && rsp_q[0].due <= cycle) begin
			$display("no acknowledge for the access due in cycle %0d", rsp_q[0].due);
			proto_errors++;
			void'(rsp_q.pop_front());
		end
		// latch state two cycles after each strobe
		if (latch_q.size() > 0 && latch_q[0].due == cycle) begin
			latch_e = latch_q.pop_front();
			check_latch(latch, debug_led, latch_e.latch, latch_e.led);
		end
	end

	initial begin : stimulus
		int          base;
		logic        we;
		logic        rnd;
		logic [3:0]  idx;
		logic [31:0] wdata;
		logic [31:0] exp_data;

		rst_n = 1'b0;
		req_stb = 1'b0;
		req = '0;
		joy0 = 5'h1F;
		joy1 = 5'h1F;
		rng_state = 32'h46c6;
		data_errors = 0;
		proto_errors = 0;
		num_cases = 0;
		for (int i = 0; i < POD_REGS; i++) begin
			pod_model[i] = 16'h0000;
		end
		$readmemh("test/io_cases.txt", case_mem);
		while (num_cases < MAX_CASES && case_mem[num_cases*FIELDS] < 32'h0000_00FF) begin
			num_cases++;
		end
		if (num_cases == 0) begin
			$display("no cases could be read from test/io_cases.txt");
			proto_errors++;
		end

		repeat (10) @(posedge clkcpu);
		#1;
		rst_n = 1'b1;

		for (int n = 0; n < num_cases; n++) begin
			base     = n * FIELDS;
			we       = case_mem[base+1][0];
			rnd      = case_mem[base+2][0];
			idx      = case_mem[base+3][3:0];
			wdata    = case_mem[base+4];
			exp_data = case_mem[base+7];
			// generated podule data goes into a model for the later reads
			if (rnd && we) begin
				rng_state      = xorshift(rng_state);
				wdata          = rng_state;
				pod_model[idx] = rng_state[15:0];
			end else if (rnd) begin
				exp_data = {16'h0000, pod_model[idx]};
			end
			req_stb = 1'b0;
			repeat (case_mem[base][7:0]) begin
				@(posedge clkcpu);
				#1;
			end
			req_stb   = 1'b1;
			req.we    = we;
			req.addr  = case_mem[base+3][23:0];
			req.wdata = wdata;
			joy0      = case_mem[base+5][4:0];
			joy1      = case_mem[base+6][4:0];
			rsp_q.push_back('{due: cycle + 32'd3, is_read: !we, rsp: exp_data});
			latch_q.push_back('{due: cycle + 32'd2, led: case_mem[base+8][13],
				latch: case_mem[base+8][12:0]});
			@(posedge clkcpu);
			#1;
		end
		req_stb = 1'b0;

		while (rsp_q.size() > 0 || latch_q.size() > 0) begin
			@(posedge clkcpu);
		end
		// room for a stray acknowledge
		repeat (4) @(posedge clkcpu);

		$display("errors: %0d wrong values, %0d protocol failures", data_errors, proto_errors);
		if (data_errors == 0 && proto_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// the case count is final once reset is released
	initial begin : watchdog
		@(posedge rst_n);
		#((num_cases + 20) * 4 * 8);
		$display("timed out before all %0d accesses were acknowledged", num_cases);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- archimedes_io.f
logic/archimedes_io_pkg.sv
logic/io_access_decode.sv
logic/io_reg_bank.sv
logic/io_latches.sv
logic/io_execute.sv
logic/io_read_return.sv
logic/archimedes_io_top.sv
test/tb_archimedes_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
	--top-module tb_archimedes_io -f archimedes_io.f -o tb_archimedes_io

sim_out=$(./obj_dir/tb_archimedes_io)
echo "$sim_out"

if grep -qx "Verification passed" <<< "$sim_out"; then
	exit 0
fi
exit 1

//--- test/io_cases.txt
// gap we rnd addr wdata joy0 joy1 exp_rdata exp_led_latch, all hex, addr is byte address 25:2
// rnd 1 takes podule data from the generator, exp_led_latch is {debug_led, latch_out_t}
1 0 0 C80000 00000000 1F 1F 00000000 3FC0
0 0 0 C80007 00000000 1F 1F 00000000 3FC0
0 0 0 C10000 00000000 1F 1F 00000000 3FC0
0 0 0 C1000F 00000000 1F 1F 00000000 3FC0
0 0 0 CD4000 00000000 1F 1F 000000FF 3FC0
// ioc bytes from bits 23:16, podule halfwords from 15:0, read right behind the write
1 1 0 C80003 12A5C3F0 1F 1F 00000000 3FC0
0 0 0 C80003 00000000 1F 1F 000000A5 3FC0
0 1 0 C80005 FF5AFFFF 1F 1F 00000000 3FC0
0 0 0 C80005 00000000 1F 1F 0000005A 3FC0
1 1 0 C10002 ABCD1234 1F 1F 00000000 3FC0
0 0 0 C10002 00000000 1F 1F 00001234 3FC0
1 1 1 C10006 00000000 1F 1F 00000000 3FC0
0 1 1 C10009 00000000 1F 1F 00000000 3FC0
0 0 1 C10006 00000000 1F 1F 00000000 3FC0
0 0 1 C10009 00000000 1F 1F 00000000 3FC0
// latches A, B and C, then the joystick port
1 1 0 CD4000 00300000 1F 1F 00000000 0180
1 0 0 CD4000 00000000 1F 1F 00000030 0180
0 1 0 CD4001 000A0000 1F 1F 00000000 01B0
0 1 0 CD4002 000D0000 1F 1F 00000000 01B7
0 0 0 CD4002 00000000 1F 1F 0000000D 01B7
1 0 0 CD4003 00000000 15 1A 000000AA 01B7
// outside I/O, bank 3, ioc bank without bit 21, latch bank at speed 0
1 0 0 880000 00000000 15 1A FFFFFFFF 01B7
0 1 0 880003 FFFFFFFF 1F 1F 00000000 01B7
0 0 0 C0C000 00000000 1F 1F FFFFFFFF 01B7
0 1 0 C00003 00FF0000 1F 1F 00000000 01B7
0 1 0 C94000 00FF0000 1F 1F 00000000 01B7
0 0 0 C94000 00000000 1F 1F FFFFFFFF 01B7
0 1 0 C0C002 FFFFFFFF 1F 1F 00000000 01B7
0 0 0 C80003 00000000 1F 1F 000000A5 01B7
0 0 0 C10002 00000000 1F 1F 00001234 01B7
0 0 0 CD4000 00000000 1F 1F 00000030 01B7
// end marker
FF
